//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_line_memory_port
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- burst_collector.sv
`timescale 1ns/1ps
`include "line_mem_settings.svh"

module burst_collector
import line_mem_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    input   beat_t          bmem_rdata_i,
    input   logic           bmem_rvalid_i,
    input   addr_t          bmem_raddr_i,

    line_fill_if.collector  fill
);

    logic       armed;      // fill started, beats still due
    beat_idx_t  beat_cnt;
    logic       done_q;
    addr_t      exp_addr;   // line address memory should echo
    line_t      line_q;

    logic       take_beat;
    logic       last_beat;

    assign take_beat = armed && bmem_rvalid_i;
    assign last_beat = (beat_cnt == beat_idx_t'(`LM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            armed    <= 1'b0;
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;     // single cycle pulse
            if (fill.fill_start) begin
                armed    <= 1'b1;
                beat_cnt <= '0;
            end else if (take_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    armed  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // lowest beat lands in the lowest slot
    always_ff @(posedge clk) begin
        if (fill.fill_start) begin
            exp_addr <= fill.fill_addr;
        end
        if (take_beat && !fill.fill_start) begin
            line_q[beat_cnt*`LM_BEAT_BITS +: `LM_BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign fill.fill_line = line_q;     // held until the next fill
    assign fill.fill_done = done_q;

    // every beat belongs to the line the arbiter asked for
    raddr_match: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (bmem_raddr_i == exp_addr))
        else $error("returned beat address differs from the requested line");

    // memory must not return beats nobody asked for
    beat_expected: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> armed)
        else $error("read beat arrived with no fill in progress");

endmodule : burst_collector

//--- burst_streamer.sv
`timescale 1ns/1ps
`include "line_mem_settings.svh"

module burst_streamer
import line_mem_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    input   logic       drain_start_i,
    input   line_t      drain_line_i,

    input   logic       bmem_ready_i,
    output  logic       bmem_write_o,
    output  beat_t      bmem_wdata_o,

    output  logic       drain_done_o
);

    logic       busy;       // beats still to be accepted
    beat_idx_t  beat_cnt;
    logic       done_q;
    line_t      line_q;

    logic       beat_taken;
    logic       last_beat;

    assign beat_taken = busy && bmem_ready_i;
    assign last_beat  = (beat_cnt == beat_idx_t'(`LM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (drain_start_i) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_taken) begin
                if (last_beat) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;     // one cycle after the last accept
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (drain_start_i) begin
            line_q <= drain_line_i;
        end
    end

    // current beat, held while memory is not ready
    assign bmem_write_o = busy;
    assign bmem_wdata_o = line_q[beat_cnt*`LM_BEAT_BITS +: `LM_BEAT_BITS];
    assign drain_done_o = done_q;

    // arbiter starts a new drain only after the previous one finished
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        drain_start_i |-> !busy)
        else $error("drain started while a drain is running");

endmodule : burst_streamer

//--- line_arbiter.sv
`timescale 1ns/1ps
`include "line_mem_settings.svh"

module line_arbiter
import line_mem_pkg::*;
(
    input   logic               clk,
    input   logic               rst,

    // instruction side
    input   addr_t              i_addr_i,
    input   logic               i_read_i,
    output  line_t              i_rdata_o,
    output  logic               i_resp_o,

    // data side
    input   addr_t              d_addr_i,
    input   logic               d_read_i,
    input   logic               d_write_i,
    input   line_t              d_wdata_i,
    output  line_t              d_rdata_o,
    output  logic               d_resp_o,

    // burst memory
    input   logic               bmem_ready_i,
    output  addr_t              bmem_addr_o,
    output  logic               bmem_read_o,

    line_fill_if.arbiter        fill,

    output  logic               drain_start_o,
    output  line_t              drain_line_o,
    input   logic               drain_done_i
);

    arb_state_e state, state_next;

    logic       owner_d;        // data requester owns the transaction
    addr_t      addr_q;         // line address of the transaction
    logic       drain_start_q;

    logic       d_req;
    logic       any_req;

    assign d_req   = d_read_i || d_write_i;
    assign any_req = d_req || i_read_i;

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (any_req) begin
                    state_next = (d_req && d_write_i) ? WRITE_DRAIN : READ_ISSUE;
                end
            end
            READ_ISSUE: begin
                if (bmem_ready_i) begin
                    state_next = READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (fill.fill_done) begin
                    state_next = RESPOND;
                end
            end
            WRITE_DRAIN: begin
                if (drain_done_i) begin
                    state_next = RESPOND;
                end
            end
            RESPOND:    state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            owner_d       <= 1'b0;
            drain_start_q <= 1'b0;
        end else begin
            state         <= state_next;
            drain_start_q <= 1'b0;
            if (state == IDLE && any_req) begin
                owner_d       <= d_req;             // data side wins a tie
                drain_start_q <= d_req && d_write_i;
            end
        end
    end

    // address held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == IDLE && any_req) begin
            addr_q <= d_req ? d_addr_i : i_addr_i;
        end
    end

    assign bmem_addr_o = addr_q;
    assign bmem_read_o = (state == READ_ISSUE) && bmem_ready_i;

    // collector arms in the same cycle as the read strobe
    assign fill.fill_start = bmem_read_o;
    assign fill.fill_addr  = addr_q;

    // data requester keeps its write line stable until resp
    assign drain_start_o = drain_start_q;
    assign drain_line_o  = d_wdata_i;

    // fill line stays valid until the next fill starts
    assign i_rdata_o = fill.fill_line;
    assign d_rdata_o = fill.fill_line;

    assign i_resp_o = (state == RESPOND) && !owner_d;
    assign d_resp_o = (state == RESPOND) && owner_d;

    // accepted address is a line address
    line_aligned: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE && any_req) |=> (addr_q[`LM_OFFSET_BITS-1:0] == '0))
        else $error("requester presented an unaligned line address");

    // one read strobe under ready, then none until the line is back
    single_read: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_ready_i ##1 (!bmem_read_o throughout fill.fill_done [->1]))
        else $error("read strobe without ready or before the fill completed");

endmodule : line_arbiter

//--- line_fill_if.sv
`timescale 1ns/1ps

interface line_fill_if
import line_mem_pkg::*;
();

    logic   fill_start;     // pulse with the memory read strobe
    addr_t  fill_addr;      // line address expected back from memory
    line_t  fill_line;      // assembled line
    logic   fill_done;      // pulse once the line is complete

    modport arbiter (
        output  fill_start,
        output  fill_addr,
        input   fill_line,
        input   fill_done
    );

    modport collector (
        input   fill_start,
        input   fill_addr,
        output  fill_line,
        output  fill_done
    );

endinterface : line_fill_if

//--- line_mem_pkg.sv
`include "line_mem_settings.svh"

package line_mem_pkg;

    typedef logic [`LM_ADDR_BITS-1:0]       addr_t;     // byte address
    typedef logic [`LM_BEAT_BITS-1:0]       beat_t;     // two words
    typedef logic [`LM_LINE_BITS-1:0]       line_t;     // eight words

    // position of a beat inside its line
    typedef logic [$clog2(`LM_BEATS)-1:0]   beat_idx_t;

    // line arbiter FSM
    typedef enum logic [2:0] {
        IDLE,           // waiting for a requester
        READ_ISSUE,     // read strobe waits for memory ready
        READ_WAIT,      // collector is gathering beats
        WRITE_DRAIN,    // streamer is sending beats
        RESPOND         // resp pulse to the owner
    } arb_state_e;

endpackage : line_mem_pkg

//--- line_mem_settings.svh
`ifndef LINE_MEM_SETTINGS_SVH
`define LINE_MEM_SETTINGS_SVH

// byte address of the burst memory
`define LM_ADDR_BITS    32

// one memory beat and one cache line
`define LM_BEAT_BITS    64
`define LM_LINE_BITS    256

// beats needed to move a line
`define LM_BEATS        4

// low address bits inside a line, zero on a line address
`define LM_OFFSET_BITS  5

`endif

//--- line_memory_port.sv
`timescale 1ns/1ps

module line_memory_port
import line_mem_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // instruction requester
    input   addr_t      i_addr_i,
    input   logic       i_read_i,
    output  line_t      i_rdata_o,
    output  logic       i_resp_o,

    // data requester
    input   addr_t      d_addr_i,
    input   logic       d_read_i,
    input   logic       d_write_i,
    input   line_t      d_wdata_i,
    output  line_t      d_rdata_o,
    output  logic       d_resp_o,

    // burst memory
    output  addr_t      bmem_addr_o,
    output  logic       bmem_read_o,
    output  logic       bmem_write_o,
    output  beat_t      bmem_wdata_o,
    input   logic       bmem_ready_i,

    input   addr_t      bmem_raddr_i,
    input   beat_t      bmem_rdata_i,
    input   logic       bmem_rvalid_i
);

    logic   drain_start;
    line_t  drain_line;
    logic   drain_done;

    line_fill_if fill_bus ();   // arbiter to collector

    line_arbiter line_arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .i_addr_i       (i_addr_i),
        .i_read_i       (i_read_i),
        .i_rdata_o      (i_rdata_o),
        .i_resp_o       (i_resp_o),
        .d_addr_i       (d_addr_i),
        .d_read_i       (d_read_i),
        .d_write_i      (d_write_i),
        .d_wdata_i      (d_wdata_i),
        .d_rdata_o      (d_rdata_o),
        .d_resp_o       (d_resp_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .fill           (fill_bus.arbiter),
        .drain_start_o  (drain_start),
        .drain_line_o   (drain_line),
        .drain_done_i   (drain_done)
    );

    burst_collector burst_collector_i (
        .clk            (clk),
        .rst            (rst),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .fill           (fill_bus.collector)
    );

    // write beats go straight to memory
    burst_streamer burst_streamer_i (
        .clk            (clk),
        .rst            (rst),
        .drain_start_i  (drain_start),
        .drain_line_i   (drain_line),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .drain_done_o   (drain_done)
    );

endmodule : line_memory_port

//--- line_patterns.txt
# port op line_addr wdata expected_word0, all hex; R read, W write (data port), expected unused
# B reads on both ports in one cycle: D reads line_addr, I reads the line in the wdata column
I R 00001000 00000000 00001000
I R 00001020 00000000 00001020
D R 00001040 00000000 00001040
D W 00002000 cafef00d 00000000
D R 00002000 00000000 cafef00d
I R 00002000 00000000 cafef00d
D W 00002020 12345678 00000000
D W 00002040 0badc0de 00000000
I R 00002040 00000000 0badc0de
D R 00002020 00000000 12345678
D W 00002000 5a5a5a5a 00000000
I R 00002000 00000000 5a5a5a5a
D B 00003000 00003100 00003000
D B 00002020 00002040 12345678
D W 00004060 a5a5a5a5 00000000
D B 00004060 00004080 a5a5a5a5
I R 00004060 00000000 a5a5a5a5
D R 00005fe0 00000000 00005fe0
I R 0000ffe0 00000000 0000ffe0
D W 0000ffe0 00c0ffee 00000000
D R 0000ffe0 00000000 00c0ffee
D B 0000ffe0 00001000 00c0ffee

//--- src.f
+incdir+.
line_mem_pkg.sv
line_fill_if.sv
burst_collector.sv
burst_streamer.sv
line_arbiter.sv
line_memory_port.sv
tb_line_memory_port.sv

//--- tb_line_memory_port.sv
`timescale 1ns/1ps
`include "line_mem_settings.svh"

module tb_line_memory_port
import line_mem_pkg::*;
();

    localparam int RESP_TIMEOUT = 400;     // cycles per response

    logic   clk;
    logic   rst;
    addr_t  i_addr;
    logic   i_read;
    line_t  i_rdata;
    logic   i_resp;
    addr_t  d_addr;
    logic   d_read;
    logic   d_write;
    line_t  d_wdata;
    line_t  d_rdata;
    logic   d_resp;
    addr_t  bmem_addr;
    logic   bmem_read;
    logic   bmem_write;
    beat_t  bmem_wdata;

    // driven by the memory model only
    logic   bmem_ready  = 1'b0;
    addr_t  bmem_raddr  = '0;
    beat_t  bmem_rdata  = '0;
    logic   bmem_rvalid = 1'b0;

    line_t          mem [addr_t];       // sparse burst memory
    logic [15:0]    lfsr_q = 16'd11;
    logic           rd_busy = 1'b0;
    addr_t          rd_addr = '0;
    int             rd_beat = 0;
    int             wr_beat = 0;
    line_t          wr_line = '0;
    addr_t          wr_exp_addr = '0;   // line the next drain must target
    line_t          wr_exp_line = '0;
    int             wr_lines = 0;
    addr_t          last_waddr = '0;

    int     check_count = 0;
    int     err_count = 0;
    int     fail_count = 0;             // timeouts and other plain failures
    int     i_resp_total = 0;
    int     d_resp_total = 0;
    int     i_expected = 0;
    int     d_expected = 0;
    int     writes_done = 0;

    line_memory_port line_memory_port_i (
        .clk(clk), .rst(rst),
        .i_addr_i(i_addr), .i_read_i(i_read), .i_rdata_o(i_rdata), .i_resp_o(i_resp),
        .d_addr_i(d_addr), .d_read_i(d_read), .d_write_i(d_write), .d_wdata_i(d_wdata),
        .d_rdata_o(d_rdata), .d_resp_o(d_resp),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_wdata_o(bmem_wdata), .bmem_ready_i(bmem_ready),
        .bmem_raddr_i(bmem_raddr), .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input line_t got, input line_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        return lfsr_q[0];
    endfunction

    // untouched memory holds each word's own byte address
    function automatic line_t model_line(input addr_t a);
        line_t l;
        if (mem.exists(a)) begin
            return mem[a];
        end
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = a + 32'(k * 4);
        end
        return l;
    endfunction

    always @(posedge clk) begin : mem_model
        logic   a_bit;
        logic   b_bit;
        line_t  rl;
        if (rst) begin
            bmem_ready  <= 1'b0;
            bmem_rvalid <= 1'b0;
            rd_busy = 1'b0;
            wr_beat = 0;
        end else begin
            if (bmem_read) begin
                if (rd_busy) begin
                    fail_count++;
                    $display("memory got a new read while a burst was still returning");
                end
                rd_busy = 1'b1;
                rd_addr = bmem_addr;
                rd_beat = 0;
            end
            if (bmem_write && bmem_ready) begin     // beat accepted
                check(line_t'(bmem_addr), line_t'(wr_exp_addr), "write beat address");
                check(line_t'(bmem_wdata), line_t'(wr_exp_line[wr_beat*`LM_BEAT_BITS +: `LM_BEAT_BITS]),
                      "write beat data");
                wr_line[wr_beat*`LM_BEAT_BITS +: `LM_BEAT_BITS] = bmem_wdata;
                wr_beat++;
                if (wr_beat == `LM_BEATS) begin
                    mem[bmem_addr] = wr_line;
                    last_waddr = bmem_addr;
                    wr_lines++;
                    wr_beat = 0;
                end
            end
            bmem_rvalid <= 1'b0;
            if (rd_busy) begin
                a_bit = lfsr_bit();
                b_bit = lfsr_bit();
                if (!(a_bit && b_bit)) begin        // otherwise a gap
                    rl = model_line(rd_addr);
                    bmem_rvalid <= 1'b1;
                    bmem_raddr  <= rd_addr;
                    bmem_rdata  <= rl[rd_beat*`LM_BEAT_BITS +: `LM_BEAT_BITS];
                    rd_beat++;
                    if (rd_beat == `LM_BEATS) begin
                        rd_busy = 1'b0;
                    end
                end
            end
            a_bit = lfsr_bit();
            b_bit = lfsr_bit();
            bmem_ready <= !(a_bit && b_bit);        // low about one cycle in four
        end
    end

    // a resp is only legal while its requester still holds the strobe
    always @(posedge clk) begin
        if (!rst) begin
            if (i_resp) begin
                i_resp_total++;
                check(line_t'(i_read), line_t'(1'b1), "instruction resp with no request");
            end
            if (d_resp) begin
                d_resp_total++;
                check(line_t'(d_read || d_write), line_t'(1'b1), "data resp with no request");
            end
        end
    end

    task automatic single_request(input logic on_d, input logic wr, input addr_t a,
                                  input logic [31:0] w, input logic [31:0] exp0);
        line_t  got;
        int     n;
        logic   seen;
        seen = 1'b0;
        n = 0;
        got = '0;
        wr_exp_addr = a;
        wr_exp_line = {8{w}};
        @(posedge clk);
        if (on_d) begin
            d_addr  <= a;
            d_read  <= !wr;
            d_write <= wr;
            d_wdata <= {8{w}};
        end else begin
            i_addr <= a;
            i_read <= 1'b1;
        end
        while (!seen && n < RESP_TIMEOUT) begin
            @(posedge clk);
            n++;
            if (on_d ? d_resp : i_resp) begin
                seen = 1'b1;
                got = on_d ? d_rdata : i_rdata;
            end
        end
        d_read  <= 1'b0;
        d_write <= 1'b0;
        i_read  <= 1'b0;
        if (!seen) begin
            fail_count++;
            $display("timeout: no response on the %s port for line %h",
                     on_d ? "data" : "instruction", a);
        end else begin
            if (on_d) d_expected++;
            else i_expected++;
            if (wr) begin
                writes_done++;
                check(line_t'(wr_lines), line_t'(writes_done), "lines drained to memory");
                check(line_t'(last_waddr), line_t'(a), "drained line address");
                check(line_t'(wr_beat), '0, "beats left over after drain");
                check(model_line(a), {8{w}}, "memory line after write");
            end else begin
                check(line_t'(got[31:0]), line_t'(exp0), "first word of read line");
                check(got, model_line(a), "read line");
            end
        end
    endtask

    task automatic dual_request(input addr_t da, input addr_t ia, input logic [31:0] exp0);
        line_t  dl;
        line_t  il;
        int     n;
        int     d_at;
        int     i_at;
        logic   d_seen;
        logic   i_seen;
        n = 0;
        d_at = 0;
        i_at = 0;
        d_seen = 1'b0;
        i_seen = 1'b0;
        dl = '0;
        il = '0;
        @(posedge clk);
        d_addr <= da;
        d_read <= 1'b1;
        i_addr <= ia;
        i_read <= 1'b1;
        while (!(d_seen && i_seen) && n < 2 * RESP_TIMEOUT) begin
            @(posedge clk);
            n++;
            if (d_resp && !d_seen) begin
                d_seen = 1'b1;
                d_at = n;
                dl = d_rdata;
                d_read <= 1'b0;
            end
            if (i_resp && !i_seen) begin
                i_seen = 1'b1;
                i_at = n;
                il = i_rdata;
                i_read <= 1'b0;
            end
        end
        d_read <= 1'b0;
        i_read <= 1'b0;
        if (!(d_seen && i_seen)) begin
            fail_count++;
            $display("timeout: simultaneous reads of %h and %h did not both complete", da, ia);
        end else begin
            d_expected++;
            i_expected++;
            check(line_t'(d_at < i_at), line_t'(1'b1), "data resp ahead of instruction resp");
            check(line_t'(dl[31:0]), line_t'(exp0), "first word of data line");
            check(dl, model_line(da), "data line in dual read");
            check(il, model_line(ia), "instruction line in dual read");
        end
    endtask

    initial begin
        int             fd;
        int             code;
        int             fields;
        string          text;
        logic [7:0]     port;
        logic [7:0]     op;
        logic [31:0]    addr;
        logic [31:0]    word;
        logic [31:0]    exp0;
        rst     = 1'b1;
        i_addr  = '0;
        i_read  = 1'b0;
        d_addr  = '0;
        d_read  = 1'b0;
        d_write = 1'b0;
        d_wdata = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (6) begin        // quiet bus before any request
            @(posedge clk);
            check(line_t'({bmem_read, bmem_write, i_resp, d_resp}), '0, "outputs idle after reset");
        end
        fd = $fopen("line_patterns.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("could not open line_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code == 0 || text.len() < 2 || text[0] == "#") continue;
                fields = $sscanf(text, "%c %c %h %h %h", port, op, addr, word, exp0);
                if (fields != 5) begin
                    fail_count++;
                    $display("unreadable pattern line: %s", text);
                    continue;
                end
                case (op)
                    "R":        single_request(port == "D", 1'b0, addr, word, exp0);
                    "W":        single_request(1'b1, 1'b1, addr, word, exp0);
                    "B":        dual_request(addr, word, exp0);
                    default: begin
                        fail_count++;
                        $display("unknown operation in pattern line: %s", text);
                    end
                endcase
            end
            $fclose(fd);
        end
        repeat (20) @(posedge clk);     // late or repeated responses would show here
        check(line_t'(i_resp_total), line_t'(i_expected), "instruction resp count");
        check(line_t'(d_resp_total), line_t'(d_expected), "data resp count");
        $display("checks %0d, errors %0d, other failures %0d", check_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_line_memory_port
